/* source/cdb_pkg.sv */
// ##################################################
// Shared definitions of the writeback stage
// Bus widths, execution unit count, result payload
// ##################################################

`default_nettype none

package cdb_pkg;

    // Width of a result value
    localparam int XLEN = 32;

    // Execution units on the bus, unit 0 is the load/store path
    localparam int EU_N = 4;

    // Units that share the bus round-robin
    localparam int RS_N = EU_N - 1;

    // Width of a unit index on the bus
    localparam int EU_IDX_LEN = $clog2(EU_N);

    // Width of a ROB entry index
    localparam int ROB_IDX_LEN = 4;

    // Width of an exception code
    localparam int EXCEPT_LEN = 5;

    // Result as it travels on the bus, 42 bits
    typedef struct packed {
        // Destination ROB entry
        logic [ROB_IDX_LEN-1:0] rob_idx;
        // Computed value
        logic [XLEN-1:0]        res_value;
        // Exception flag and its cause
        logic                   except_raised;
        logic [EXCEPT_LEN-1:0]  except_code;
    } cdb_data_t;

endpackage

`default_nettype wire

/* source/eu_result_buffer.sv */
// ##################################################
// One-entry result buffer in front of the bus
// Holds a finished result until the bus takes it
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module eu_result_buffer (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               flush_i,

    // From the execution unit
    input  logic               valid_i,
    input  cdb_pkg::cdb_data_t data_i,
    output logic               ready_o,

    // Towards the bus
    output logic               valid_o,
    output cdb_pkg::cdb_data_t data_o,
    input  logic               ready_i
);

    import cdb_pkg::*;

    // Stored result and its valid bit
    logic      valid_q;
    cdb_data_t data_q;

    // Handshake events
    logic      drain;
    logic      load;

    // Bus takes the stored result this cycle
    assign drain = valid_q & ready_i;

    // Free slot or slot freed in the same cycle, never during flush
    assign ready_o = (~valid_q | drain) & ~flush_i;
    assign load    = valid_i & ready_o;

    // Valid bit
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // Drop whatever is held
            valid_q <= 1'b0;
        end else if (load) begin
            // New result wins over a drain in the same cycle
            valid_q <= 1'b1;
        end else if (drain) begin
            valid_q <= 1'b0;
        end
    end

    // Payload register
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
// ##################################################
// Bus arbiter for the common data bus
// Unit 0 has fixed top priority, others round-robin
// Grant is held while the ROB applies back-pressure
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    input  logic                             flush_i,

    // Maximum priority unit handshake
    input  logic                             max_prio_valid_i,
    output logic                             max_prio_ready_o,

    // Low priority unit handshakes
    input  logic [0:cdb_pkg::EU_N-2]         valid_i,
    output logic [0:cdb_pkg::EU_N-2]         ready_o,

    // ROB handshake
    input  logic                             rob_ready_i,
    output logic                             rob_valid_o,

    // Selection for the data multiplexer
    output logic                             served_max_prio_o,
    output logic [cdb_pkg::EU_IDX_LEN-1:0]   served_o
);

    import cdb_pkg::*;

    // Round-robin pointer, index among the low priority units
    logic [EU_IDX_LEN-1:0] rr_ptr_q;
    logic [EU_IDX_LEN-1:0] rr_ptr_d;

    // Grant frozen from the previous stalled cycle
    logic                  lock_q;
    logic                  lock_max_prio_q;
    logic [EU_IDX_LEN-1:0] lock_idx_q;

    // Round-robin search result
    logic                  rr_found;
    logic [EU_IDX_LEN-1:0] rr_idx;

    // Final selection of this cycle
    logic                  sel_max_prio;
    logic [EU_IDX_LEN-1:0] sel_idx;
    logic                  any_req;
    logic                  xfer;

    // Search from the pointer, wrapping over the low priority units
    always_comb begin
        int cand;
        rr_found = 1'b0;
        rr_idx   = rr_ptr_q;
        for (int i = 0; i < RS_N; i++) begin
            cand = int'(rr_ptr_q) + i;
            if (cand >= RS_N) begin
                cand = cand - RS_N;
            end
            // First valid unit after the pointer wins
            if (!rr_found && valid_i[cand]) begin
                rr_found = 1'b1;
                rr_idx   = EU_IDX_LEN'(cand);
            end
        end
    end

    // Held grant keeps the bus stable until the ROB takes it
    always_comb begin
        if (lock_q) begin
            sel_max_prio = lock_max_prio_q;
            sel_idx      = lock_idx_q;
        end else begin
            sel_max_prio = max_prio_valid_i;
            sel_idx      = rr_idx;
        end
    end

    // A held grant always belongs to a full buffer, so a request stays present
    assign any_req     = max_prio_valid_i | rr_found;
    assign rob_valid_o = any_req & ~flush_i;
    assign xfer        = rob_valid_o & rob_ready_i;

    // Only the served unit sees the ROB ready
    assign max_prio_ready_o = xfer & sel_max_prio;

    always_comb begin
        for (int i = 0; i < RS_N; i++) begin
            ready_o[i] = xfer & ~sel_max_prio & (sel_idx == EU_IDX_LEN'(i));
        end
    end

    // Pointer moves past a served low priority unit
    always_comb begin
        rr_ptr_d = rr_ptr_q;
        if (xfer && !sel_max_prio) begin
            if (sel_idx == EU_IDX_LEN'(RS_N - 1)) begin
                rr_ptr_d = '0;
            end else begin
                rr_ptr_d = sel_idx + 1'b1;
            end
        end
    end

    // Pointer and grant lock, both cleared by flush
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q        <= '0;
            lock_q          <= 1'b0;
            lock_max_prio_q <= 1'b0;
            lock_idx_q      <= '0;
        end else if (flush_i) begin
            // Restart round-robin at unit 1
            rr_ptr_q        <= '0;
            lock_q          <= 1'b0;
            lock_max_prio_q <= 1'b0;
            lock_idx_q      <= '0;
        end else begin
            rr_ptr_q        <= rr_ptr_d;
            // Offered but not taken
            lock_q          <= rob_valid_o & ~rob_ready_i;
            lock_max_prio_q <= sel_max_prio;
            lock_idx_q      <= sel_idx;
        end
    end

    // Selection towards the data multiplexer
    assign served_max_prio_o = sel_max_prio;
    assign served_o          = sel_idx;

endmodule

`default_nettype wire

/* source/cdb.sv */
// ##################################################
// Common data bus towards the ROB
// Arbiter instance and result multiplexer
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module cdb (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                flush_i,

    // Maximum priority unit, the load/store path
    input  logic                max_prio_valid_i,
    output logic                max_prio_ready_o,
    input  cdb_pkg::cdb_data_t  max_prio_data_i,

    // Low priority units
    input  logic [0:cdb_pkg::EU_N-2] rs_valid_i,
    output logic [0:cdb_pkg::EU_N-2] rs_ready_o,
    input  cdb_pkg::cdb_data_t  rs_data_i [0:cdb_pkg::EU_N-2],

    // ROB side
    input  logic                rob_ready_i,
    output logic                rob_valid_o,
    output cdb_pkg::cdb_data_t  rob_data_o
);

    import cdb_pkg::*;

    // Result picked among the low priority units
    cdb_data_t             low_prio_mux_data;

    // Served unit from the arbiter
    logic                  served_max_prio;
    logic [EU_IDX_LEN-1:0] served;

    // Handshake steering
    cdb_arbiter u_cdb_arbiter (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .flush_i           (flush_i),
        .max_prio_valid_i  (max_prio_valid_i),
        .max_prio_ready_o  (max_prio_ready_o),
        .valid_i           (rs_valid_i),
        .ready_o           (rs_ready_o),
        .rob_ready_i       (rob_ready_i),
        .rob_valid_o       (rob_valid_o),
        .served_max_prio_o (served_max_prio),
        .served_o          (served)
    );

    // Low priority mux, index among units 1 and up
    assign low_prio_mux_data = rs_data_i[served];

    // Load/store result overrides the low priority pick
    assign rob_data_o = served_max_prio ? max_prio_data_i : low_prio_mux_data;

endmodule

`default_nettype wire

/* source/wb_cdb_top.sv */
// ##################################################
// Writeback stage top level
// One result buffer per execution unit and the bus
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module wb_cdb_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   flush_i,

    // Execution units, unit 0 is the load/store path
    input  logic [0:cdb_pkg::EU_N-1] eu_valid_i,
    output logic [0:cdb_pkg::EU_N-1] eu_ready_o,
    input  cdb_pkg::cdb_data_t     eu_data_i [0:cdb_pkg::EU_N-1],

    // ROB side
    input  logic                   rob_ready_i,
    output logic                   rob_valid_o,
    output cdb_pkg::cdb_data_t     rob_data_o
);

    import cdb_pkg::*;

    // Buffer to bus wires, one per unit
    logic [0:EU_N-1] buf_valid;
    logic [0:EU_N-1] buf_ready;
    cdb_data_t       buf_data [0:EU_N-1];

    // Result buffers
    for (genvar k = 0; k < EU_N; k++) begin : g_buf
        eu_result_buffer u_eu_result_buffer (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .flush_i  (flush_i),
            .valid_i  (eu_valid_i[k]),
            .data_i   (eu_data_i[k]),
            .ready_o  (eu_ready_o[k]),
            .valid_o  (buf_valid[k]),
            .data_o   (buf_data[k]),
            .ready_i  (buf_ready[k])
        );
    end

    // Bus, buffer 0 on the max priority port
    // Buffers 1 and up on the round-robin ports
    cdb u_cdb (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .flush_i          (flush_i),
        .max_prio_valid_i (buf_valid[0]),
        .max_prio_ready_o (buf_ready[0]),
        .max_prio_data_i  (buf_data[0]),
        .rs_valid_i       (buf_valid[1:EU_N-1]),
        .rs_ready_o       (buf_ready[1:EU_N-1]),
        .rs_data_i        (buf_data[1:EU_N-1]),
        .rob_ready_i      (rob_ready_i),
        .rob_valid_o      (rob_valid_o),
        .rob_data_o       (rob_data_o)
    );

endmodule

`default_nettype wire

/* dv/cdb_props.sv */
// ##################################################
// Handshake properties of the common data bus
// Bound into every cdb instance
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module cdb_props (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     flush_i,
    input logic                     max_prio_valid_i,
    input logic                     max_prio_ready_o,
    input logic [0:cdb_pkg::EU_N-2] rs_valid_i,
    input logic [0:cdb_pkg::EU_N-2] rs_ready_o,
    input logic                     rob_ready_i,
    input logic                     rob_valid_o,
    input cdb_pkg::cdb_data_t       rob_data_o
);

    import cdb_pkg::*;

    // All buffer requests and grants side by side
    logic [RS_N:0] all_valid;
    logic [RS_N:0] all_ready;

    assign all_valid = {max_prio_valid_i, rs_valid_i};
    assign all_ready = {max_prio_ready_o, rs_ready_o};

    // Single grant per cycle and only to a full buffer
    ready_onehot: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(all_ready) && ((all_ready & ~all_valid) == '0)
    ) else $error("bus granted to more than one buffer or to an empty one");

    // Nothing reaches the ROB in a flush cycle or the cycle after it
    no_valid_on_flush: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rob_valid_o |-> (!flush_i && !$past(flush_i))
    ) else $error("rob_valid_o high during or right after flush");

    // Offer stays put until the ROB takes it
    stable_on_stall: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (rob_valid_o && !rob_ready_i && !flush_i)
            |=> (flush_i || (rob_valid_o && $stable(rob_data_o)))
    ) else $error("bus offer changed under back-pressure");

endmodule

bind cdb cdb_props u_cdb_props (.*);

`default_nettype wire

/* dv/tb_wb_cdb_top.sv */
// ##################################################
// Testbench for the writeback stage
// Random units and ROB, reference model, checks
// Watchdog bounding the whole run
// ##################################################

`timescale 1ns/1ps
`default_nettype none

module tb_wb_cdb_top;

    import cdb_pkg::*;

    // Cycle budget of each test
    localparam int RESET_CYC = 8;
    localparam int RAND_CYC  = 400;
    localparam int PRIO_CYC  = 200;
    localparam int ROT_CYC   = 150;
    localparam int BP_CYC    = 240;
    localparam int FLUSH_CYC = 320;
    localparam int DRAIN_CYC = 20;
    localparam int WD_CYC    = RESET_CYC + RAND_CYC + PRIO_CYC + ROT_CYC
                             + BP_CYC + FLUSH_CYC + DRAIN_CYC + 100;

    // DUT ports
    logic            clk_i;
    logic            arst_n_i;
    logic            flush_i;
    logic [0:EU_N-1] eu_valid_i;
    logic [0:EU_N-1] eu_ready_o;
    cdb_data_t       eu_data_i [0:EU_N-1];
    logic            rob_ready_i;
    logic            rob_valid_o;
    cdb_data_t       rob_data_o;

    // Reference model, one pending slot per unit
    logic            pend_v [0:EU_N-1];
    cdb_data_t       pend_d [0:EU_N-1];
    int              rr_ptr;
    // Offer that the ROB has not taken yet
    logic            held;
    logic            held_max;
    int              held_idx;
    // Last low priority unit served, for the rotation check
    int              last_low;
    logic            prev_stall;
    cdb_data_t       prev_data;

    // Counters
    int              err_cnt;
    int              chk_cnt;
    int              acc_cnt;
    int              xfer_cnt;
    int              drop_cnt;

    wb_cdb_top u_wb_cdb_top (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (flush_i),
        .eu_valid_i  (eu_valid_i),
        .eu_ready_o  (eu_ready_o),
        .eu_data_i   (eu_data_i),
        .rob_ready_i (rob_ready_i),
        .rob_valid_o (rob_valid_o),
        .rob_data_o  (rob_data_o)
    );

    // 40 ns clock
    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    // Empty slots, pointer back at unit 1
    task automatic clear_model();
        for (int k = 0; k < EU_N; k++) begin
            pend_v[k] = 1'b0;
        end
        rr_ptr   = 0;
        held     = 1'b0;
        held_max = 1'b0;
        held_idx = 0;
        last_low = EU_N - 1;
    endtask

    // First pending low priority unit from the pointer, index among units 1 and up
    function automatic int first_low(input int ptr);
        int c;
        for (int i = 0; i < EU_N - 1; i++) begin
            c = (ptr + i) % (EU_N - 1);
            if (pend_v[c + 1]) begin
                return c;
            end
        end
        return ptr;
    endfunction

    function automatic cdb_data_t random_result();
        cdb_data_t r;
        r.rob_idx       = ROB_IDX_LEN'($urandom);
        r.res_value     = $urandom;
        r.except_raised = ($urandom % 8) == 0;
        r.except_code   = EXCEPT_LEN'($urandom);
        return r;
    endfunction

    // Random units and ROB, percentages per cycle
    // Nonzero stall_len gives ROB phases of stall_len low then 8 high
    task automatic run_traffic(input int cycles, input int p_first, input int p_rest,
                               input int p_rob, input int p_flush, input int stall_len);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk_i);
            for (int k = 0; k < EU_N; k++) begin
                eu_valid_i[k] <= ($urandom % 100) < (k == 0 ? p_first : p_rest);
                eu_data_i[k]  <= random_result();
            end
            if (stall_len > 0) begin
                rob_ready_i <= (n % (stall_len + 8)) >= stall_len;
            end else begin
                rob_ready_i <= ($urandom % 100) < p_rob;
            end
            flush_i <= ($urandom % 100) < p_flush;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_cnt == err_before) begin
            $display("[PASS] %s", name);
        end else begin
            $display("[FAIL] %s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    // Model step and compare, outputs settled at the falling edge
    always @(negedge clk_i) begin : model_step
        logic            any_req;
        logic            sel_max;
        int              sel_idx;
        int              unit;
        logic            exp_valid;
        logic            xfer;
        logic            low_full;
        logic [0:EU_N-1] exp_ready;
        if (arst_n_i !== 1'b1) begin
            clear_model();
            prev_stall = 1'b0;
        end else begin
            any_req  = 1'b0;
            low_full = 1'b1;
            for (int k = 0; k < EU_N; k++) begin
                any_req = any_req | pend_v[k];
                if (k > 0 && !pend_v[k]) begin
                    low_full = 1'b0;
                end
            end
            // An untaken offer stays on the bus
            if (held) begin
                sel_max = held_max;
                sel_idx = held_idx;
            end else begin
                sel_max = pend_v[0];
                sel_idx = first_low(rr_ptr);
            end
            unit      = sel_max ? 0 : sel_idx + 1;
            exp_valid = any_req & ~flush_i;
            xfer      = exp_valid & rob_ready_i;
            for (int k = 0; k < EU_N; k++) begin
                exp_ready[k] = (!pend_v[k] || (xfer && unit == k)) && !flush_i;
            end

            chk_cnt++;
            assert (rob_valid_o === exp_valid) else begin
                $display("ERR %0t: rob_valid_o %b, expected %b", $time, rob_valid_o, exp_valid);
                err_cnt++;
            end
            assert (eu_ready_o === exp_ready) else begin
                $display("ERR %0t: eu_ready_o %b, expected %b", $time, eu_ready_o, exp_ready);
                err_cnt++;
            end
            if (exp_valid) begin
                assert (rob_data_o === pend_d[unit]) else begin
                    $display("ERR %0t: rob_data_o %h, expected %h from unit %0d",
                             $time, rob_data_o, pend_d[unit], unit);
                    err_cnt++;
                end
            end
            if (prev_stall && !flush_i) begin
                assert (rob_valid_o === 1'b1 && rob_data_o === prev_data) else begin
                    $display("ERR %0t: bus changed under back-pressure", $time);
                    err_cnt++;
                end
            end
            // Rotation 1, 2, 3 while every low priority buffer is full
            if (exp_valid && !held && !pend_v[0] && low_full) begin
                assert (rob_data_o === pend_d[last_low % (EU_N - 1) + 1]) else begin
                    $display("ERR %0t: round-robin skipped unit %0d",
                             $time, last_low % (EU_N - 1) + 1);
                    err_cnt++;
                end
            end

            prev_stall = exp_valid & ~rob_ready_i;
            prev_data  = pend_d[unit];
            if (flush_i) begin
                for (int k = 0; k < EU_N; k++) begin
                    if (pend_v[k]) begin
                        drop_cnt++;
                    end
                end
                clear_model();
            end else begin
                if (xfer) begin
                    xfer_cnt++;
                    pend_v[unit] = 1'b0;
                    if (!sel_max) begin
                        rr_ptr   = (sel_idx + 1) % (EU_N - 1);
                        last_low = unit;
                    end
                end
                // Load after drain, a new result refills the slot
                for (int k = 0; k < EU_N; k++) begin
                    if (eu_valid_i[k] && exp_ready[k]) begin
                        pend_v[k] = 1'b1;
                        pend_d[k] = eu_data_i[k];
                        acc_cnt++;
                    end
                end
                held     = exp_valid & ~rob_ready_i;
                held_max = sel_max;
                held_idx = sel_idx;
            end
        end
    end

    // Test sequence
    initial begin : run
        int e0;
        logic left;
        void'($urandom(32'h74f3c5c1));
        err_cnt     = 0;
        chk_cnt     = 0;
        acc_cnt     = 0;
        xfer_cnt    = 0;
        drop_cnt    = 0;
        arst_n_i    = 1'b0;
        flush_i     = 1'b0;
        rob_ready_i = 1'b0;
        eu_valid_i  = '0;
        for (int k = 0; k < EU_N; k++) begin
            eu_data_i[k] = '0;
        end
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Idle bus right after reset
        e0 = err_cnt;
        @(negedge clk_i);
        assert (rob_valid_o === 1'b0 && eu_ready_o === '1) else begin
            $display("ERR %0t: bus not idle after reset", $time);
            err_cnt++;
        end
        run_traffic(RESET_CYC, 0, 0, 100, 0, 0);
        report_test("reset state", e0);

        e0 = err_cnt;
        run_traffic(RAND_CYC, 50, 50, 75, 0, 0);
        report_test("random traffic", e0);

        e0 = err_cnt;
        run_traffic(PRIO_CYC, 80, 60, 70, 0, 0);
        report_test("load/store priority", e0);

        e0 = err_cnt;
        run_traffic(ROT_CYC, 0, 100, 100, 0, 0);
        report_test("round-robin rotation", e0);

        e0 = err_cnt;
        run_traffic(BP_CYC, 60, 60, 0, 0, 16);
        report_test("back-pressure", e0);

        // Random flushes, then one flush with every unit valid and a full restart
        e0 = err_cnt;
        run_traffic(FLUSH_CYC - 21, 40, 70, 60, 5, 0);
        run_traffic(1, 100, 100, 100, 100, 0);
        run_traffic(20, 0, 100, 100, 0, 0);
        report_test("flush", e0);

        // Units idle until every buffer is empty
        e0 = err_cnt;
        run_traffic(DRAIN_CYC, 0, 0, 100, 0, 0);
        @(posedge clk_i);
        left = 1'b0;
        for (int k = 0; k < EU_N; k++) begin
            left = left | pend_v[k];
        end
        assert (!left && acc_cnt == xfer_cnt + drop_cnt) else begin
            $display("Results lost: %0d accepted, %0d transferred, %0d flushed, pending %b",
                     acc_cnt, xfer_cnt, drop_cnt, left);
            err_cnt++;
        end
        report_test("drain", e0);

        $display("Done: %0d checks, %0d errors, %0d results transferred",
                 chk_cnt, err_cnt, xfer_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WD_CYC * 40);
        $display("Watchdog timeout: the run did not end within its cycle budget");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/cdb_pkg.sv
source/eu_result_buffer.sv
source/cdb_arbiter.sv
source/cdb.sv
source/wb_cdb_top.sv
dv/cdb_props.sv
dv/tb_wb_cdb_top.sv

/* Bender.yml */
package:
  name: wb_cdb

sources:
  # Package first, then leaf modules up to the top level
  - source/cdb_pkg.sv
  - source/eu_result_buffer.sv
  - source/cdb_arbiter.sv
  - source/cdb.sv
  - source/wb_cdb_top.sv

  # Testbench and bound properties
  - target: test
    files:
      - dv/cdb_props.sv
      - dv/tb_wb_cdb_top.sv
